// ==== compile.f ====
hw/edsac_pkg.sv
hw/event_link_if.sv
hw/control_debounce.sv
hw/event_fifo.sv
hw/edsac_control.sv
hw/edsac_panel_top.sv
dv/edsac_panel_assert.sv
dv/edsac_panel_tb.sv

// ==== dv/edsac_panel_assert.sv ====
module edsac_panel_assert (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         tick,
  input logic                         empty,
  input edsac_pkg::ctl_event_e        ev,
  input logic                         running,
  input logic                         stopped_by_order,
  input logic [edsac_pkg::ADDR_W-1:0] order_counter
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of assertion failures so far
  int fail_count = 0;

  // Pushes come at most once per tick and each event is popped at once,
  // so the queue never holds an event for two cycles and cannot fill up
  a_queue_drains: assert property (@(posedge clk) disable iff (!rst_n) !empty |=> empty)
    else begin
      $error("event queue still held an event a cycle after it was popped");
      fail_count++;
    end

  // A stop order leaves the machine halted, never running at the same time
  a_run_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(running && stopped_by_order))
    else begin
      $error("running and stopped_by_order both high");
      fail_count++;
    end

  // Counter moves on a step tick, a start or an extended load, nothing else
  a_cnt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !(tick || ev == edsac_pkg::EV_START || ev == edsac_pkg::EV_EXTENDED)
    |=> $stable(order_counter))
    else begin
      $error("order_counter changed without tick, start or extended");
      fail_count++;
    end

endmodule

bind edsac_control edsac_panel_assert u_assert (
  .clk              (clk),
  .rst_n            (rst_n),
  .tick             (link.tick),
  .empty            (link.empty),
  .ev               (ev),
  .running          (running),
  .stopped_by_order (stopped_by_order),
  .order_counter    (order_counter)
);

// ==== dv/edsac_panel_tb.sv ====
module edsac_panel_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TICK_DIV = 4;
  localparam int NT       = 16;
  // Button mask bits, same order as the priority chain
  localparam logic [4:0] B_STOP   = 5'b00001;
  localparam logic [4:0] B_START  = 5'b00010;
  localparam logic [4:0] B_RESUME = 5'b00100;
  localparam logic [4:0] B_SINGLE = 5'b01000;
  localparam logic [4:0] B_EXT    = 5'b10000;

  logic                          clk;
  logic                          rst_n;
  logic                          start_btn;
  logic                          stop_btn;
  logic                          resume_btn;
  logic                          single_ep_btn;
  logic                          extended_btn;
  logic [edsac_pkg::ORDER_W-1:0] panel_order;
  logic                          eng_mode;
  logic                          running;
  logic [edsac_pkg::ADDR_W-1:0]  order_counter;
  logic [edsac_pkg::ORDER_W-1:0] order_reg;
  logic                          stopped_by_order;

  // Scenario table, one slot per test
  string                         t_name  [NT];
  logic [4:0]                    t_btn   [NT];
  int                            t_hold  [NT];
  int                            t_wait  [NT];
  logic [edsac_pkg::ORDER_W-1:0] t_panel [NT];
  logic                          t_eng   [NT];
  logic                          t_run   [NT];
  int                            t_cnt   [NT];
  logic [edsac_pkg::ORDER_W-1:0] t_ord   [NT];
  logic                          t_stop  [NT];

  int errors;
  int failed_tests;
  int cycle_cnt;
  int cycle_limit;

  edsac_panel_top #(
    .TICK_DIV (TICK_DIV)
  ) dut0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_btn        (start_btn),
    .stop_btn         (stop_btn),
    .resume_btn       (resume_btn),
    .single_ep_btn    (single_ep_btn),
    .extended_btn     (extended_btn),
    .panel_order      (panel_order),
    .eng_mode         (eng_mode),
    .running          (running),
    .order_counter    (order_counter),
    .order_reg        (order_reg),
    .stopped_by_order (stopped_by_order)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Watchdog on total run length
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: run went past its limit of %0d cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  // Pack an order word from its fields: func, spare, address, long flag
  function automatic logic [edsac_pkg::ORDER_W-1:0] order_bits(
    input logic [4:0] func, input logic [9:0] addr, input logic long_flag);
    return {func, 1'b0, addr, long_flag};
  endfunction

  // Word a normal step leaves in the order register
  function automatic logic [edsac_pkg::ORDER_W-1:0] seq_order(input int addr);
    return order_bits(5'd0, addr[9:0], 1'b0);
  endfunction

  task automatic set_entry(input int i, input string name, input logic [4:0] btn,
                           input int hold, input int wait_t,
                           input logic [edsac_pkg::ORDER_W-1:0] panel, input logic eng,
                           input logic run, input int cnt,
                           input logic [edsac_pkg::ORDER_W-1:0] ord, input logic stop);
    t_name[i]  = name;
    t_btn[i]   = btn;
    t_hold[i]  = hold;
    t_wait[i]  = wait_t;
    t_panel[i] = panel;
    t_eng[i]   = eng;
    t_run[i]   = run;
    t_cnt[i]   = cnt;
    t_ord[i]   = ord;
    t_stop[i]  = stop;
  endtask

  // Counts: a run steps once per tick after the event lands two clocks past its tick
  task automatic load_table();
    set_entry(0, "start_run", B_START, 3, 4, '0, 1'b0, 1'b1, 4, seq_order(4), 1'b0);
    set_entry(1, "stop_run", B_STOP, 3, 2, '0, 1'b0, 1'b0, 8, seq_order(8), 1'b0);
    set_entry(2, "stay_stopped", 5'b0, 0, 4, '0, 1'b0, 1'b0, 8, seq_order(8), 1'b0);
    set_entry(3, "single_step", B_SINGLE, 3, 2, '0, 1'b0, 1'b0, 9, seq_order(9), 1'b0);
    // Two ticks held is below the debounce count
    set_entry(4, "short_press", B_SINGLE, 2, 3, '0, 1'b0, 1'b0, 9, seq_order(9), 1'b0);
    set_entry(5, "long_hold", B_SINGLE, 8, 2, '0, 1'b0, 1'b0, 10, seq_order(10), 1'b0);
    set_entry(6, "start_again", B_START, 3, 3, '0, 1'b0, 1'b1, 3, seq_order(3), 1'b0);
    set_entry(7, "single_running", B_SINGLE, 3, 1, '0, 1'b0, 1'b1, 8, seq_order(8), 1'b0);
    set_entry(8, "stop_for_eng", B_STOP, 3, 1, '0, 1'b0, 1'b0, 12, seq_order(12), 1'b0);
    set_entry(9, "eng_single", B_SINGLE, 3, 2, order_bits(5'd5, 10'h155, 1'b1), 1'b1,
              1'b0, 13, order_bits(5'd5, 10'h155, 1'b1), 1'b0);
    // Resume runs into a stop order loaded from the panel
    set_entry(10, "eng_stop_order", B_RESUME, 3, 2,
              order_bits(edsac_pkg::STOP_FUNC, 10'd3, 1'b0), 1'b1,
              1'b0, 14, order_bits(edsac_pkg::STOP_FUNC, 10'd3, 1'b0), 1'b1);
    set_entry(11, "resume_clears", B_RESUME, 3, 2, '0, 1'b0, 1'b1, 16, seq_order(16), 1'b0);
    set_entry(12, "stop_again", B_STOP, 3, 1, '0, 1'b0, 1'b0, 20, seq_order(20), 1'b0);
    set_entry(13, "extended_load", B_EXT, 3, 1, order_bits(5'd0, 10'h2a5, 1'b0), 1'b0,
              1'b0, 'h2a5, seq_order(20), 1'b0);
    set_entry(14, "extended_single", B_SINGLE, 3, 2, '0, 1'b0, 1'b0, 'h2a6,
              seq_order('h2a6), 1'b0);
    // Stop wins the tick, start follows one tick later
    set_entry(15, "stop_start_same", B_STOP | B_START, 3, 5, '0, 1'b0, 1'b1, 4,
              seq_order(4), 1'b0);
  endtask

  // Four-state compare, so an unknown output never passes
  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("ERROR %s %s expected 'h%0h actual 'h%0h", name, what, expected, actual);
      errors++;
    end
  endtask

  // Land on the clock edge that carries an order-rate tick
  task automatic align_to_tick();
    @(negedge clk);
    while (dut0.link0.tick !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic run_entry(input int i);
    int err_before;
    int asrt_before;
    err_before  = errors;
    asrt_before = dut0.u_control.u_assert.fail_count;
    align_to_tick();
    panel_order <= t_panel[i];
    eng_mode    <= t_eng[i];
    {extended_btn, single_ep_btn, resume_btn, start_btn, stop_btn} <= t_btn[i];
    // Hold spans exactly t_hold ticks after the synchronizer
    repeat (t_hold[i] * TICK_DIV) @(posedge clk);
    {extended_btn, single_ep_btn, resume_btn, start_btn, stop_btn} <= 5'b0;
    repeat (t_wait[i] * TICK_DIV) @(posedge clk);
    @(negedge clk);
    check_value(t_name[i], "running", t_run[i], running);
    check_value(t_name[i], "order_counter", t_cnt[i], order_counter);
    check_value(t_name[i], "order_reg", t_ord[i], order_reg);
    check_value(t_name[i], "stopped_by_order", t_stop[i], stopped_by_order);
    if (dut0.u_control.u_assert.fail_count != asrt_before) begin
      $display("ERROR %s: a bound assertion on the controller failed during the test",
               t_name[i]);
      errors++;
    end
    if (errors != err_before) begin
      failed_tests++;
    end
    $display("Test %0d %s: %s", i, t_name[i], (errors == err_before) ? "passed" : "failed");
  endtask

  initial begin
    errors        = 0;
    failed_tests  = 0;
    cycle_cnt     = 0;
    rst_n         <= 1'b0;
    start_btn     <= 1'b0;
    stop_btn      <= 1'b0;
    resume_btn    <= 1'b0;
    single_ep_btn <= 1'b0;
    extended_btn  <= 1'b0;
    panel_order   <= '0;
    eng_mode      <= 1'b0;
    load_table();
    cycle_limit = 0;
    for (int i = 0; i < NT; i++) begin
      cycle_limit += (t_hold[i] + t_wait[i] + 4) * TICK_DIV;
    end
    cycle_limit = 2 * cycle_limit;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NT; i++) begin
      run_entry(i);
    end
    $display("Tests %0d, passed %0d, failed %0d, check errors %0d",
             NT, NT - failed_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== hw/control_debounce.sv ====
module control_debounce #(
  parameter int TICK_DIV       = 200,
  parameter int DEBOUNCE_TICKS = 3
) (
  input logic        clk,
  input logic        rst_n,
  input logic        start_btn,
  input logic        stop_btn,
  input logic        resume_btn,
  input logic        single_ep_btn,
  input logic        extended_btn,
  event_link_if.prod link
);

  localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
  localparam int CNT_W = $clog2(DEBOUNCE_TICKS + 1);
  // Five buttons, index 0 has the highest priority
  localparam int NBTN  = 5;

  logic [DIV_W-1:0] div_cnt;
  logic             tick_q;
  logic [NBTN-1:0]  btn_raw;
  logic [NBTN-1:0]  sync1;
  logic [NBTN-1:0]  sync2;
  logic [NBTN-1:0]  db;
  logic [NBTN-1:0]  pending;
  logic [NBTN-1:0]  accept;
  logic [NBTN-1:0]  cand;
  logic [NBTN-1:0]  pick;
  logic [CNT_W-1:0] stable_cnt [NBTN];
  edsac_pkg::ctl_event_e pick_code;

  // Map a button index to its event code
  function automatic edsac_pkg::ctl_event_e btn_event(input int idx);
    case (idx)
      0:       return edsac_pkg::EV_STOP;
      1:       return edsac_pkg::EV_START;
      2:       return edsac_pkg::EV_RESUME;
      3:       return edsac_pkg::EV_SINGLE;
      4:       return edsac_pkg::EV_EXTENDED;
      default: return edsac_pkg::EV_NONE;
    endcase
  endfunction

  // Priority order: stop, start, resume, single, extended
  assign btn_raw = {extended_btn, single_ep_btn, resume_btn, start_btn, stop_btn};

  assign link.tick = tick_q;

  // Clock divider for the order rate
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
      tick_q  <= 1'b0;
    end else begin
      tick_q <= (div_cnt == DIV_W'(TICK_DIV - 1));
      if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Two-flop synchronizer on every button
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync1 <= '0;
      sync2 <= '0;
    end else begin
      sync1 <= btn_raw;
      sync2 <= sync1;
    end
  end

  // Press accepted on the tick that completes the stable count
  always_comb begin
    for (int i = 0; i < NBTN; i++) begin
      accept[i] = sync2[i] && !db[i] && (stable_cnt[i] == CNT_W'(DEBOUNCE_TICKS - 1));
    end
  end

  // Earlier accepted presses compete with fresh ones
  assign cand = pending | accept;

  // Lowest index wins, so scan from the top down
  always_comb begin
    pick      = '0;
    pick_code = edsac_pkg::EV_NONE;
    for (int i = NBTN - 1; i >= 0; i--) begin
      if (cand[i]) begin
        pick      = '0;
        pick[i]   = 1'b1;
        pick_code = btn_event(i);
      end
    end
  end

  // Stable counters saturate, debounced state drops only when the button falls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      db <= '0;
      for (int i = 0; i < NBTN; i++) begin
        stable_cnt[i] <= '0;
      end
    end else if (tick_q) begin
      for (int i = 0; i < NBTN; i++) begin
        if (sync2[i]) begin
          if (stable_cnt[i] != CNT_W'(DEBOUNCE_TICKS)) begin
            stable_cnt[i] <= stable_cnt[i] + 1'b1;
          end
          if (accept[i]) begin
            db[i] <= 1'b1;
          end
        end else begin
          stable_cnt[i] <= '0;
          db[i]         <= 1'b0;
        end
      end
    end
  end

  // One push per tick; the rest wait in pending
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending        <= '0;
      link.push      <= 1'b0;
      link.push_code <= edsac_pkg::EV_NONE;
    end else if (tick_q) begin
      pending        <= cand & ~pick;
      link.push      <= |cand;
      link.push_code <= pick_code;
    end else begin
      link.push <= 1'b0;
    end
  end

endmodule

// ==== hw/edsac_control.sv ====
module edsac_control (
  input  logic                              clk,
  input  logic                              rst_n,
  input  edsac_pkg::order_word_u            panel_order,
  input  logic                              eng_mode,
  event_link_if.cons                        link,
  output logic                              running,
  output logic [edsac_pkg::ADDR_W-1:0]      order_counter,
  output edsac_pkg::order_word_u            order_reg,
  output logic                              stopped_by_order
);

  edsac_pkg::ctl_event_e          ev;
  edsac_pkg::order_word_u         step_word;
  logic [edsac_pkg::ADDR_W-1:0]   next_cnt;
  logic                           single_req;
  logic                           do_step;

  // Drain the queue as soon as anything shows up
  assign link.pop = !link.empty;

  // Event acted on this cycle
  assign ev = link.empty ? edsac_pkg::EV_NONE : link.head_code;

  // Sequence control counter, wraps at 1024
  assign next_cnt = order_counter + 1'b1;

  // Word that a step loads into the order register
  always_comb begin
    if (eng_mode) begin
      // Engineer's mode takes the panel toggles
      step_word = panel_order;
    end else begin
      // Normal run: function 0 at the new counter address
      step_word.raw         = '0;
      step_word.fields.addr = next_cnt;
    end
  end

  // Steps run at the order rate, either free running or one single order
  assign do_step = link.tick && (running || single_req);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running          <= 1'b0;
      stopped_by_order <= 1'b0;
      order_counter    <= '0;
      order_reg.raw    <= '0;
      single_req       <= 1'b0;
    end else begin
      case (ev)
        edsac_pkg::EV_START: begin
          // Restart from order 0
          order_counter    <= '0;
          stopped_by_order <= 1'b0;
          running          <= 1'b1;
          single_req       <= 1'b0;
        end
        edsac_pkg::EV_STOP: begin
          running    <= 1'b0;
          single_req <= 1'b0;
        end
        edsac_pkg::EV_RESUME: begin
          // Counter kept as it was
          running          <= 1'b1;
          stopped_by_order <= 1'b0;
        end
        edsac_pkg::EV_SINGLE: begin
          // Ignored while running
          if (!running) begin
            single_req <= 1'b1;
          end
        end
        edsac_pkg::EV_EXTENDED: begin
          order_counter <= panel_order.fields.addr;
        end
        default: begin
        end
      endcase

      // Step comes last so a stop order wins over any event
      if (do_step) begin
        order_counter <= next_cnt;
        order_reg     <= step_word;
        single_req    <= 1'b0;
        if (step_word.fields.func == edsac_pkg::STOP_FUNC) begin
          running          <= 1'b0;
          stopped_by_order <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hw/edsac_panel_top.sv ====
module edsac_panel_top #(
  parameter int TICK_DIV       = 200,
  parameter int DEBOUNCE_TICKS = 3,
  parameter int FIFO_DEPTH     = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_btn,
  input  logic                          stop_btn,
  input  logic                          resume_btn,
  input  logic                          single_ep_btn,
  input  logic                          extended_btn,
  input  logic [edsac_pkg::ORDER_W-1:0] panel_order,
  input  logic                          eng_mode,
  output logic                          running,
  output logic [edsac_pkg::ADDR_W-1:0]  order_counter,
  output logic [edsac_pkg::ORDER_W-1:0] order_reg,
  output logic                          stopped_by_order
);

  edsac_pkg::order_word_u panel_word;
  edsac_pkg::order_word_u order_word;

  // Board pins carry the raw switch pattern
  assign panel_word.raw = panel_order;
  assign order_reg      = order_word.raw;

  // Event path from buttons to controller
  event_link_if link0 ();

  control_debounce #(
    .TICK_DIV       (TICK_DIV),
    .DEBOUNCE_TICKS (DEBOUNCE_TICKS)
  ) u_debounce (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_btn     (start_btn),
    .stop_btn      (stop_btn),
    .resume_btn    (resume_btn),
    .single_ep_btn (single_ep_btn),
    .extended_btn  (extended_btn),
    .link          (link0.prod)
  );

  event_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (link0.fifo)
  );

  edsac_control u_control (
    .clk              (clk),
    .rst_n            (rst_n),
    .panel_order      (panel_word),
    .eng_mode         (eng_mode),
    .link             (link0.cons),
    .running          (running),
    .order_counter    (order_counter),
    .order_reg        (order_word),
    .stopped_by_order (stopped_by_order)
  );

endmodule

// ==== hw/edsac_pkg.sv ====
package edsac_pkg;

  // Order word layout, as on the panel toggles
  localparam int ORDER_W = 17;
  localparam int ADDR_W  = 10;
  localparam int FUNC_W  = 5;

  // Button events carried through the event queue
  // EV_NONE is what the link shows when nothing is pending
  typedef enum logic [2:0] {
    EV_NONE     = 3'd0,
    EV_START    = 3'd1,
    EV_STOP     = 3'd2,
    EV_RESUME   = 3'd3,
    EV_SINGLE   = 3'd4,
    EV_EXTENDED = 3'd5
  } ctl_event_e;

  // Function code of the stop order (Z in the teleprinter code)
  localparam logic [FUNC_W-1:0] STOP_FUNC = 5'd13;

  // One order word, seen either as the switch pattern or as decoded fields
  typedef union packed {
    logic [ORDER_W-1:0] raw;
    struct packed {
      // Function code, top five bits
      logic [FUNC_W-1:0] func;
      // Unused bit between function and address
      logic              spare;
      // Store address of the order
      logic [ADDR_W-1:0] addr;
      // Short or long number flag
      logic              long_flag;
    } fields;
  } order_word_u;

endpackage

// ==== hw/event_fifo.sv ====
module event_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input logic        clk,
  input logic        rst_n,
  event_link_if.fifo link
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  edsac_pkg::ctl_event_e mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W:0]        count;
  logic                  full;
  logic                  do_push;
  logic                  do_pop;

  // Status from the occupancy count
  assign full       = (count == (PTR_W + 1)'(FIFO_DEPTH));
  assign link.empty = (count == '0);

  // Head of the queue is visible without a read strobe
  assign link.head_code = mem[rd_ptr];

  // A push into a full queue is lost
  assign do_push = link.push && !full;
  assign do_pop  = link.pop && !link.empty;

  // Storage array
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= link.push_code;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== hw/event_link_if.sv ====
interface event_link_if;

  // Order-rate tick, one clock wide
  logic tick;

  // Producer side of the queue
  logic                  push;
  edsac_pkg::ctl_event_e push_code;

  // Consumer side of the queue
  logic                  empty;
  edsac_pkg::ctl_event_e head_code;
  logic                  pop;

  // Button front end, writes events and owns the tick
  modport prod (output push, output push_code, output tick);

  // Event queue between the two
  modport fifo (
    input  push,
    input  push_code,
    output empty,
    output head_code,
    input  pop
  );

  // Run controller, drains the queue and steps on tick
  modport cons (input empty, input head_code, input tick, output pop);

endinterface
